//--- src/eth_rx_pkg.sv
// 10G Ethernet receive definitions
// XGMII character codes, CRC-32 constants, the XGMII word union,
// FSM state codes and the byte-wise CRC helpers
`default_nettype none

package eth_rx_pkg;

    typedef logic [7:0] xgmii_ctrl_t;
    typedef logic [7:0] lane_mask_t;

    // one XGMII data word, seen as byte lanes or as two halves
    typedef union packed {
        logic [7:0][7:0]  lane;
        logic [1:0][31:0] half;
    } xgmii_data_u;

    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM  = 8'hfd;
    localparam logic [7:0] XGMII_ERROR = 8'hfe;

    localparam logic [63:0] XGMII_IDLE_WORD = {8{XGMII_IDLE}};

    localparam logic [31:0] CRC_INIT      = 32'hffff_ffff;
    // register value after a good frame plus its FCS, not inverted
    localparam logic [31:0] CRC_RESIDUE   = 32'hdebb_20e3;
    localparam logic [31:0] CRC_POLY_REFL = 32'hedb8_8320;

    localparam int FCS_BYTES = 4;

    // frame sequencer states
    localparam logic [1:0] SEQ_IDLE    = 2'd0;
    localparam logic [1:0] SEQ_PAYLOAD = 2'd1;
    localparam logic [1:0] SEQ_LAST    = 2'd2;

    // advance a reflected CRC-32 by one byte, lsb first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY_REFL) : (c >> 1);
        end
        return c;
    endfunction

    // lanes that lie below the first terminate, all lanes if there is none
    function automatic lane_mask_t live_lanes(input lane_mask_t term);
        lane_mask_t first;
        first = term & (~term + 8'd1);
        return (|term) ? lane_mask_t'(first - 8'd1) : 8'hff;
    endfunction

endpackage

`default_nettype wire

//--- src/xgmii_word_if.sv
// Aligned XGMII word
// one word per clock with its control mask and the per-lane
// start, terminate and error detections
`default_nettype none

interface xgmii_word_if ();
    import eth_rx_pkg::*;

    xgmii_data_u data;
    xgmii_ctrl_t ctrl;
    // start only ever shows up on lane 0 after alignment
    lane_mask_t  start;
    lane_mask_t  term;
    lane_mask_t  err;

    modport source (
        output data, ctrl, start, term, err
    );

    modport sink (
        input data, ctrl, start, term, err
    );

endinterface

`default_nettype wire

//--- src/rx_beat_if.sv
// Receive beat
// one stream beat from the frame sequencer, FCS already removed
`default_nettype none

interface rx_beat_if ();
    import eth_rx_pkg::*;

    xgmii_data_u data;
    logic [7:0]  keep;
    logic        valid;
    logic        last;
    // framing problem seen by the sequencer, set with last only
    logic        bad_frame;

    modport source (
        output data, keep, valid, last, bad_frame
    );

    modport sink (
        input data, keep, valid, last, bad_frame
    );

endinterface

`default_nettype wire

//--- src/xgmii_lane_align.sv
// XGMII lane aligner
// registers the XGMII input, shifts frames that start on lane 4
// down by half a word so every start sits on lane 0, and decodes
// start, terminate and error characters per lane
`default_nettype none

module xgmii_lane_align (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [63:0]             xgmii_rxd,
    input  eth_rx_pkg::xgmii_ctrl_t xgmii_rxc,
    xgmii_word_if.source            word
);
    import eth_rx_pkg::*;

    xgmii_data_u rxd_in;
    xgmii_data_u rxd_q;
    xgmii_ctrl_t rxc_q;
    logic [31:0] hold_d;
    logic [3:0]  hold_c;
    logic        swapped;
    logic        start_l0;
    logic        start_l4;

    assign rxd_in   = xgmii_rxd;
    assign start_l0 = xgmii_rxc[0] && (rxd_in.lane[0] == XGMII_START);
    assign start_l4 = xgmii_rxc[4] && (rxd_in.lane[4] == XGMII_START);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            swapped <= 1'b0;
            rxd_q   <= XGMII_IDLE_WORD;
            rxc_q   <= '1;
        end else if (start_l0) begin
            swapped <= 1'b0;
            rxd_q   <= rxd_in;
            rxc_q   <= xgmii_rxc;
        end else if (start_l4 && !swapped) begin
            // start half waits a cycle, lower half goes out with idle on top
            swapped <= 1'b1;
            rxd_q   <= {XGMII_IDLE_WORD[63:32], rxd_in.half[0]};
            rxc_q   <= {4'hf, xgmii_rxc[3:0]};
        end else if (swapped) begin
            rxd_q <= {rxd_in.half[0], hold_d};
            rxc_q <= {xgmii_rxc[3:0], hold_c};
        end else begin
            rxd_q <= rxd_in;
            rxc_q <= xgmii_rxc;
        end
    end

    // upper half kept for the next combined word
    always_ff @(posedge clk) begin
        hold_d <= rxd_in.half[1];
        hold_c <= xgmii_rxc[7:4];
    end

    assign word.data = rxd_q;
    assign word.ctrl = rxc_q;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            word.start[i] = rxc_q[i] && (rxd_q.lane[i] == XGMII_START);
            word.term[i]  = rxc_q[i] && (rxd_q.lane[i] == XGMII_TERM);
            word.err[i]   = rxc_q[i] && (rxd_q.lane[i] == XGMII_ERROR);
        end
    end

    // input starts on lane 0 or 4 only, so the swap leaves none elsewhere
    a_start_lane0: assert property (@(posedge clk) disable iff (rst) word.start[7:1] == '0)
        else $error("start character off lane 0 after alignment");

endmodule

`default_nettype wire

//--- src/rx_frame_sequencer.sv
// Receive frame sequencer
// follows frame boundaries on the aligned word stream, holds one
// word back so the FCS bytes can be cut off, and ends frames early
// with bad_frame on error or stray control characters
`default_nettype none

module rx_frame_sequencer (
    input  logic       clk,
    input  logic       rst,
    xgmii_word_if.sink word,
    rx_beat_if.source  beat
);
    import eth_rx_pkg::*;

    logic [1:0]  state_q;
    logic [1:0]  state_d;
    xgmii_data_u prev_data;
    logic        prev_start;
    logic [7:0]  tail_keep_q;
    logic [7:0]  tail_keep_d;

    lane_mask_t  live;
    logic        err_hit;
    logic        ctrl_hit;
    logic        term_hit;
    logic [2:0]  term_lane;
    logic [7:0]  keep_end;
    logic [7:0]  keep_tail;

    xgmii_data_u data_d;
    logic [7:0]  keep_d;
    logic        valid_d;
    logic        last_d;
    logic        bad_d;

    assign live     = live_lanes(word.term);
    assign err_hit  = |(word.err & live);
    assign ctrl_hit = |(word.ctrl & ~word.err & live);
    assign term_hit = |word.term;

    always_comb begin
        term_lane = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (word.term[i]) begin
                term_lane = 3'(i);
            end
        end
    end

    // terminate on lanes 0..4 ends inside the held word
    assign keep_end  = 8'hff >> (3'd4 - term_lane);
    // terminate on lanes 5..7 leaves 1..3 bytes for an extra beat
    assign keep_tail = 8'hff >> (4'd12 - {1'b0, term_lane});

    always_comb begin
        state_d     = state_q;
        tail_keep_d = tail_keep_q;
        data_d      = prev_data;
        keep_d      = 8'hff;
        valid_d     = 1'b0;
        last_d      = 1'b0;
        bad_d       = 1'b0;
        case (state_q)
            SEQ_IDLE: begin
                if (prev_start) begin
                    if (err_hit || ctrl_hit || term_hit) begin
                        // broken first word, report a single byte
                        data_d  = '0;
                        keep_d  = 8'h01;
                        valid_d = 1'b1;
                        last_d  = 1'b1;
                        bad_d   = 1'b1;
                    end else begin
                        state_d = SEQ_PAYLOAD;
                    end
                end
            end
            SEQ_PAYLOAD: begin
                valid_d = 1'b1;
                if (err_hit || ctrl_hit) begin
                    // also covers a new start, which idle then picks up
                    last_d  = 1'b1;
                    bad_d   = 1'b1;
                    state_d = SEQ_IDLE;
                end else if (term_hit) begin
                    if (|word.term[FCS_BYTES:0]) begin
                        keep_d  = keep_end;
                        last_d  = 1'b1;
                        state_d = SEQ_IDLE;
                    end else begin
                        tail_keep_d = keep_tail;
                        state_d     = SEQ_LAST;
                    end
                end
            end
            SEQ_LAST: begin
                keep_d  = tail_keep_q;
                valid_d = 1'b1;
                last_d  = 1'b1;
                state_d = SEQ_IDLE;
            end
            default: begin
                state_d = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q        <= SEQ_IDLE;
            prev_start     <= 1'b0;
            beat.valid     <= 1'b0;
            beat.last      <= 1'b0;
            beat.bad_frame <= 1'b0;
        end else begin
            state_q        <= state_d;
            prev_start     <= word.start[0];
            beat.valid     <= valid_d;
            beat.last      <= last_d;
            beat.bad_frame <= bad_d;
        end
    end

    always_ff @(posedge clk) begin
        prev_data   <= word.data;
        tail_keep_q <= tail_keep_d;
        beat.data   <= data_d;
        beat.keep   <= keep_d;
    end

    // every run of beats opens two or three words after a start word
    a_gap_after_last: assert property (@(posedge clk) disable iff (rst)
        beat.valid && !$past(beat.valid) |->
            $past(word.start[0], 2) || $past(word.start[0], 3))
        else $error("beat outside a frame");

endmodule

`default_nettype wire

//--- src/rx_fcs_check.sv
// Receive FCS checker
// runs CRC-32 over every frame byte including the FCS and compares
// the register with the fixed residue when the frame terminates
`default_nettype none

module rx_fcs_check (
    input  logic       clk,
    input  logic       rst,
    xgmii_word_if.sink word,
    output logic       fcs_done,
    output logic       fcs_ok
);
    import eth_rx_pkg::*;

    lane_mask_t  live;
    logic        ctrl_hit;
    logic        in_frame;
    logic [31:0] crc_q;
    logic [31:0] crc_d;

    assign live     = live_lanes(word.term);
    assign ctrl_hit = |(word.ctrl & live);

    // bytes up to the terminate lane, one lane after another
    always_comb begin
        crc_d = crc_q;
        for (int i = 0; i < 8; i++) begin
            if (live[i]) begin
                crc_d = crc32_byte(crc_d, word.data.lane[i]);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_frame <= 1'b0;
            fcs_done <= 1'b0;
            fcs_ok   <= 1'b0;
        end else begin
            fcs_done <= 1'b0;
            if (word.start[0]) begin
                in_frame <= 1'b1;
            end else if (in_frame) begin
                if (ctrl_hit) begin
                    // aborted frame, the sequencer flags it
                    in_frame <= 1'b0;
                end else if (|word.term) begin
                    in_frame <= 1'b0;
                    fcs_done <= 1'b1;
                    fcs_ok   <= (crc_d == CRC_RESIDUE);
                end
            end
        end
    end

    // preamble word is skipped, seeding happens on the start
    always_ff @(posedge clk) begin
        if (word.start[0]) begin
            crc_q <= CRC_INIT;
        end else if (in_frame) begin
            crc_q <= crc_d;
        end
    end

endmodule

`default_nettype wire

//--- src/rx_frame_output.sv
// Receive output stage
// registers the stream beats, folds the FCS verdict into tuser of
// the matching last beat and raises the status pulses
`default_nettype none

module rx_frame_output (
    input  logic        clk,
    input  logic        rst,
    rx_beat_if.sink     beat,
    input  logic        fcs_done,
    input  logic        fcs_ok,
    output logic [63:0] tdata,
    output logic [7:0]  tkeep,
    output logic        tvalid,
    output logic        tlast,
    output logic        tuser,
    output logic        error_bad_frame,
    output logic        error_bad_fcs
);

    logic pend_valid;
    logic pend_fail;
    logic end_beat;
    logic fcs_fail;
    logic frame_fail;

    assign end_beat = beat.valid && beat.last;
    // verdict may land with the last beat or a cycle before it
    assign fcs_fail   = (fcs_done && !fcs_ok) || (pend_valid && pend_fail);
    assign frame_fail = beat.bad_frame || fcs_fail;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tvalid          <= 1'b0;
            tlast           <= 1'b0;
            tuser           <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;
            pend_valid      <= 1'b0;
            pend_fail       <= 1'b0;
        end else begin
            tvalid          <= beat.valid;
            tlast           <= end_beat;
            tuser           <= end_beat && frame_fail;
            error_bad_frame <= end_beat && frame_fail;
            error_bad_fcs   <= end_beat && fcs_fail;
            if (end_beat) begin
                pend_valid <= 1'b0;
            end else if (fcs_done) begin
                pend_valid <= 1'b1;
                pend_fail  <= !fcs_ok;
            end
        end
    end

    always_ff @(posedge clk) begin
        tdata <= beat.data;
        tkeep <= beat.keep;
    end

    // checker and sequencer must stay one frame apart at most
    a_one_verdict: assert property (@(posedge clk) disable iff (rst) fcs_done |-> !pend_valid)
        else $error("FCS verdict arrived with another still pending");

endmodule

`default_nettype wire

//--- src/eth_mac_rx_top.sv
// 10G Ethernet MAC receive path
// XGMII in, stream beats out with FCS removed and checked,
// plus bad frame and bad FCS status pulses
`default_nettype none

module eth_mac_rx_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [63:0] xgmii_rxd,
    input  logic [7:0]  xgmii_rxc,
    output logic [63:0] rx_tdata,
    output logic [7:0]  rx_tkeep,
    output logic        rx_tvalid,
    output logic        rx_tlast,
    output logic        rx_tuser,
    output logic        error_bad_frame,
    output logic        error_bad_fcs
);

    xgmii_word_if word_bus ();
    rx_beat_if    beat_bus ();

    logic fcs_done;
    logic fcs_ok;

    xgmii_lane_align u_align (
        .clk       (clk),
        .rst       (rst),
        .xgmii_rxd (xgmii_rxd),
        .xgmii_rxc (xgmii_rxc),
        .word      (word_bus.source)
    );

    // sequencer and checker both watch the aligned word
    rx_frame_sequencer u_seq (
        .clk  (clk),
        .rst  (rst),
        .word (word_bus.sink),
        .beat (beat_bus.source)
    );

    rx_fcs_check u_fcs (
        .clk      (clk),
        .rst      (rst),
        .word     (word_bus.sink),
        .fcs_done (fcs_done),
        .fcs_ok   (fcs_ok)
    );

    rx_frame_output u_out (
        .clk             (clk),
        .rst             (rst),
        .beat            (beat_bus.sink),
        .fcs_done        (fcs_done),
        .fcs_ok          (fcs_ok),
        .tdata           (rx_tdata),
        .tkeep           (rx_tkeep),
        .tvalid          (rx_tvalid),
        .tlast           (rx_tlast),
        .tuser           (rx_tuser),
        .error_bad_frame (error_bad_frame),
        .error_bad_fcs   (error_bad_fcs)
    );

endmodule

`default_nettype wire

//--- tb/tb_eth_frame_model.svh
// Ethernet frame reference model
// builds the XGMII byte stream for frames at start lane 0 or 4 and
// the stream beats the receive path should deliver for them
`ifndef TB_ETH_FRAME_MODEL_SVH
`define TB_ETH_FRAME_MODEL_SVH

typedef enum int {
    FRAME_GOOD,
    FRAME_BAD_FCS,
    FRAME_ERR_CHAR,
    FRAME_CUT
} frame_kind_e;

// byte stream still to be packed into words
logic [7:0]  lane_bytes[$];
logic        lane_ctrl[$];

logic [63:0] stim_d[$];
logic [7:0]  stim_c[$];

// expected beats, the verdict flags only ever set on a last beat
logic [63:0] exp_data[$];
logic [7:0]  exp_keep[$];
logic        exp_last[$];
logic        exp_user[$];
logic        exp_fcs[$];

function automatic void put_byte(input logic [7:0] b, input logic c);
    lane_bytes.push_back(b);
    lane_ctrl.push_back(c);
endfunction

// idles until the stream reaches the given lane of a word
function automatic void pad_to_lane(input int lane);
    while (lane_bytes.size() % 8 != lane) begin
        put_byte(XGMII_IDLE, 1'b1);
    end
endfunction

function automatic void add_idle_words(input int n);
    pad_to_lane(0);
    for (int i = 0; i < n * 8; i++) begin
        put_byte(XGMII_IDLE, 1'b1);
    end
endfunction

// pack the byte stream into XGMII words, lane 0 in the low byte
function automatic void close_stream();
    logic [63:0] d;
    logic [7:0]  c;
    pad_to_lane(0);
    for (int w = 0; w < lane_bytes.size() / 8; w++) begin
        for (int i = 0; i < 8; i++) begin
            d[8 * i +: 8] = lane_bytes[8 * w + i];
            c[i]          = lane_ctrl[8 * w + i];
        end
        stim_d.push_back(d);
        stim_c.push_back(c);
    end
    lane_bytes.delete();
    lane_ctrl.delete();
endfunction

// pos is the error byte, or for a cut frame the byte where the next start sits
function automatic void append_frame(input int len, input frame_kind_e kind,
                                     input int pos, input int lane);
    logic [7:0]  payload[$];
    logic [31:0] crc;
    logic [31:0] fcs;
    logic [63:0] d;
    logic [7:0]  k;
    int          n_in;
    int          n_out;
    crc = CRC_INIT;
    for (int i = 0; i < len; i++) begin
        payload.push_back(8'($urandom));
        crc = crc32_byte(crc, payload[i]);
    end
    fcs = ~crc;
    if (kind == FRAME_BAD_FCS) begin
        fcs = fcs ^ (32'hff << (8 * ($urandom % 4)));
    end
    pad_to_lane(lane);
    put_byte(XGMII_START, 1'b1);
    for (int i = 0; i < 6; i++) begin
        put_byte(8'h55, 1'b0);
    end
    put_byte(8'hd5, 1'b0);
    n_in  = (kind == FRAME_CUT) ? pos : len;
    n_out = n_in;
    if (kind == FRAME_ERR_CHAR) begin
        // beats stop at the word before the error character
        n_out = (pos / 8) * 8;
    end
    for (int i = 0; i < n_in; i++) begin
        if (kind == FRAME_ERR_CHAR && i == pos) begin
            put_byte(XGMII_ERROR, 1'b1);
        end else begin
            put_byte(payload[i], 1'b0);
        end
    end
    if (kind != FRAME_CUT) begin
        for (int i = 0; i < FCS_BYTES; i++) begin
            put_byte(fcs[8 * i +: 8], 1'b0);
        end
        put_byte(XGMII_TERM, 1'b1);
    end
    for (int b = 0; b < n_out; b += 8) begin
        d = '0;
        k = '0;
        for (int i = 0; i < 8 && b + i < n_out; i++) begin
            d[8 * i +: 8] = payload[b + i];
            k[i]          = 1'b1;
        end
        exp_data.push_back(d);
        exp_keep.push_back(k);
        exp_last.push_back(b + 8 >= n_out);
        exp_user.push_back(b + 8 >= n_out && kind != FRAME_GOOD);
        exp_fcs.push_back(b + 8 >= n_out && kind == FRAME_BAD_FCS);
    end
endfunction

`endif

//--- tb/tb_eth_mac_rx.sv
// Testbench for the 10G Ethernet MAC receive path
// sends XGMII frames on start lanes 0 and 4, with bad FCS, error
// characters and early starts, and checks every output beat
`default_nettype none

module tb_eth_mac_rx;
    import eth_rx_pkg::*;

    `include "tb_eth_frame_model.svh"

    logic        clk;
    logic        rst;
    logic [63:0] xgmii_rxd;
    logic [7:0]  xgmii_rxc;
    logic [63:0] rx_tdata;
    logic [7:0]  rx_tkeep;
    logic        rx_tvalid;
    logic        rx_tlast;
    logic        rx_tuser;
    logic        error_bad_frame;
    logic        error_bad_fcs;

    int          word_mark[6];
    int          beat_mark[6];
    string       test_name[6];
    int          errors;
    int          beats_seen;
    int          cycle_limit;
    int          cycles;
    logic        running;

    eth_mac_rx_top dut (
        .clk             (clk),
        .rst             (rst),
        .xgmii_rxd       (xgmii_rxd),
        .xgmii_rxc       (xgmii_rxc),
        .rx_tdata        (rx_tdata),
        .rx_tkeep        (rx_tkeep),
        .rx_tvalid       (rx_tvalid),
        .rx_tlast        (rx_tlast),
        .rx_tuser        (rx_tuser),
        .error_bad_frame (error_bad_frame),
        .error_bad_fcs   (error_bad_fcs)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // frames for all six tests, with word and beat marks per test
    task automatic build_tests();
        int len;
        int lane;
        test_name[0] = "good frames, lane 0";
        test_name[1] = "good frames, lane 4";
        test_name[2] = "corrupted FCS";
        test_name[3] = "error character";
        test_name[4] = "start inside frame";
        test_name[5] = "back-to-back frames";
        for (int t = 0; t < 6; t++) begin
            for (int n = 0; n < ((t == 5) ? 10 : (t == 4) ? 3 : (t < 2) ? 8 : 4); n++) begin
                add_idle_words(1 + $urandom % 3);
                lane = (t == 0) ? 0 : (t == 1) ? 4 : 4 * ($urandom % 2);
                len  = 60 + $urandom % 141;
                case (t)
                    0, 1: append_frame(60 + n + 8 * ($urandom % 17), FRAME_GOOD, 0, lane);
                    2: append_frame(len, FRAME_BAD_FCS, 0, lane);
                    3: append_frame(len, FRAME_ERR_CHAR, 8 + $urandom % (len - 8), lane);
                    4: begin
                        append_frame(len, FRAME_CUT, 8 * (1 + $urandom % (len / 8)), lane);
                        append_frame(60 + $urandom % 141, FRAME_GOOD, 0, lane);
                    end
                    default: append_frame(len, FRAME_GOOD, 0, lane);
                endcase
            end
            // trailing idles flush the pipeline before the next test
            add_idle_words(8);
            close_stream();
            word_mark[t] = stim_d.size();
            beat_mark[t] = exp_data.size();
        end
    endtask

    always @(posedge clk) begin : compare
        logic [63:0] mask;
        if (!rst && rx_tvalid) begin
            assert (exp_data.size() > 0)
                else begin
                    $display("Error at %0t: output beat arrived with none expected", $time);
                    errors++;
                end
            if (exp_data.size() > 0) begin
                for (int i = 0; i < 8; i++) begin
                    mask[8 * i +: 8] = {8{exp_keep[0][i]}};
                end
                assert ((rx_tdata & mask) == (exp_data[0] & mask))
                    else begin
                        $display("Error at %0t: tdata %h, expected %h", $time,
                                 rx_tdata & mask, exp_data[0] & mask);
                        errors++;
                    end
                assert (rx_tkeep == exp_keep[0])
                    else begin
                        $display("Error at %0t: tkeep %h, expected %h", $time,
                                 rx_tkeep, exp_keep[0]);
                        errors++;
                    end
                assert (rx_tlast == exp_last[0] && rx_tuser == exp_user[0])
                    else begin
                        $display("Error at %0t: tlast/tuser %b%b, expected %b%b", $time,
                                 rx_tlast, rx_tuser, exp_last[0], exp_user[0]);
                        errors++;
                    end
                assert (error_bad_frame == exp_user[0] && error_bad_fcs == exp_fcs[0])
                    else begin
                        $display("Error at %0t: bad frame/fcs %b%b, expected %b%b", $time,
                                 error_bad_frame, error_bad_fcs, exp_user[0], exp_fcs[0]);
                        errors++;
                    end
                void'(exp_data.pop_front());
                void'(exp_keep.pop_front());
                void'(exp_last.pop_front());
                void'(exp_user.pop_front());
                void'(exp_fcs.pop_front());
                beats_seen++;
            end
        end else if (!rst) begin
            assert (!error_bad_frame && !error_bad_fcs)
                else begin
                    $display("Error at %0t: status pulse without an output beat", $time);
                    errors++;
                end
        end
    end

    initial begin : stimulus
        int first;
        int errs_before;
        void'($urandom(32'h0878_5330));
        rst        = 1'b1;
        xgmii_rxd  = XGMII_IDLE_WORD;
        xgmii_rxc  = 8'hff;
        errors     = 0;
        beats_seen = 0;
        running    = 1'b0;
        build_tests();
        cycle_limit = stim_d.size() + 64;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst     = 1'b0;
        running = 1'b1;
        first   = 0;
        for (int t = 0; t < 6; t++) begin
            errs_before = errors;
            for (int w = first; w < word_mark[t]; w++) begin
                @(negedge clk);
                xgmii_rxd = stim_d[w];
                xgmii_rxc = stim_c[w];
            end
            first = word_mark[t];
            while (beats_seen < beat_mark[t]) begin
                @(negedge clk);
            end
            $display("test %0d, %s: %0d errors", t + 1, test_name[t], errors - errs_before);
        end
        $display("6 tests, %0d beats checked, %0d errors", beats_seen, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        cycles = 0;
        wait (running);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: expected beats still missing after %0d cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+tb
src/eth_rx_pkg.sv
src/xgmii_word_if.sv
src/rx_beat_if.sv
src/xgmii_lane_align.sv
src/rx_frame_sequencer.sv
src/rx_fcs_check.sv
src/rx_frame_output.sv
src/eth_mac_rx_top.sv
tb/tb_eth_mac_rx.sv

//--- Bender.yml
package:
  name: eth_mac_rx

sources:
  - src/eth_rx_pkg.sv
  - src/xgmii_word_if.sv
  - src/rx_beat_if.sv
  - src/xgmii_lane_align.sv
  - src/rx_frame_sequencer.sv
  - src/rx_fcs_check.sv
  - src/rx_frame_output.sv
  - src/eth_mac_rx_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_eth_mac_rx.sv
